// ==== vlog.f ====
+incdir+hw
hw/fetch_pkg.sv
hw/fetch_ifs.sv
hw/pc_incrementer.sv
hw/pc_stage.sv
hw/apb_fetch_stage.sv
hw/predecode_stage.sv
hw/fetch_top.sv
testbench/fetch_props.sv
testbench/fetch_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = fetch_tb
FILELIST = vlog.f
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/fetch_tb.sv ====
`include "fetch_settings.svh"

module fetch_tb
    import fetch_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          num_outputs       = 3000;
    localparam int          cycles_per_output = 20;
    localparam int          clk_period        = 10;
    localparam logic [31:0] mem_limit         = 32'd1024; // 256 words.

    logic                     clk            = 1'b0;
    logic                     reset          = 1'b1;
    logic                     redirect_valid = 1'b0;
    logic [`FETCH_ADDR_W-1:0] redirect_pc    = '0;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [`FETCH_ADDR_W-1:0] paddr;
    logic [31:0]              prdata         = '0;
    logic                     pready         = 1'b0;
    logic                     pslverr        = 1'b0;
    logic                     instr_valid;
    logic                     instr_ready    = 1'b0;
    logic [`FETCH_ADDR_W-1:0] instr_pc;
    logic [31:0]              instr;
    opcode_class_e            instr_class;
    logic                     instr_fault;

    logic [31:0]   lfsr       = 32'h44ba4345;
    logic [31:0]   mem [256];
    logic          mem_filled = 1'b0;
    int            wait_left  = 0;
    int            n_xfer     = 0;
    logic [31:0]   exp_pc     = `FETCH_RESET_PC; // next pc on the current path.
    logic [31:0]   old_pc     = '0;
    int            old_state  = 0; // 0 none, 1 old word held, 2 not yet known.
    logic          stalled    = 1'b0;
    logic [31:0]   held_pc;
    logic [31:0]   held_instr;
    opcode_class_e held_class;
    logic          held_fault;

    fetch_top i_dut
    (
        .clk(clk),
        .reset(reset),
        .redirect_valid(redirect_valid),
        .redirect_pc(redirect_pc),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .instr_valid(instr_valid),
        .instr_ready(instr_ready),
        .instr_pc(instr_pc),
        .instr(instr),
        .instr_class(instr_class),
        .instr_fault(instr_fault)
    );

    // Galois LFSR, one step per bit taken.
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] bits;

        bits = '0;
        for (int i = 0; i < n; i++)
        begin
            bits = {bits[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return bits;
    endfunction

    function automatic opcode_class_e classify_word(input logic [31:0] word, input logic fault);
        if (fault || word[1:0] != 2'b11)
            return cls_illegal;
        case (word[6:0])
            7'b0110011, 7'b0010011: return cls_alu;
            7'b0000011:             return cls_load;
            7'b0100011:             return cls_store;
            7'b1100011:             return cls_branch;
            7'b1101111, 7'b1100111: return cls_jump;
            7'b0110111, 7'b0010111: return cls_upper;
            7'b1110011:             return cls_system;
            default:                return cls_illegal;
        endcase
    endfunction

    // far away, just below a 16- or 256-byte boundary, or anywhere in memory.
    function automatic logic [31:0] pick_target();
        logic [31:0] kind;
        logic [31:0] hi;
        logic [31:0] lo;
        logic [31:0] target;

        kind = lfsr_bits(2);
        if (kind == 0)
            target = lfsr_bits(32);
        else if (kind == 1)
        begin
            hi     = lfsr_bits(2);
            lo     = lfsr_bits(4);
            target = {22'd0, hi[1:0], 4'hf, lo[3:0]};
        end
        else if (kind == 2)
        begin
            hi     = lfsr_bits(6);
            lo     = lfsr_bits(2);
            target = {22'd0, hi[5:0], 2'b11, lo[1:0]};
        end
        else
        begin
            target = lfsr_bits(10);
            if (lfsr_bits(1) != 0)
                target[1:0] = 2'b00;
        end
        return target;
    endfunction

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display(">>> FAIL");
        $fatal(1, "run stopped");
    endtask

    always #(clk_period / 2) clk = ~clk;

    always @(posedge clk)
    begin
        logic [31:0] pc_expect;
        logic [31:0] word_expect;
        logic        fault_expect;

        if (reset)
        begin
            if (!mem_filled)
            begin
                for (int i = 0; i < 256; i++)
                    mem[i] = lfsr_bits(32);
                mem_filled = 1'b1;
            end
        end
        else
        begin
            if (stalled)
            begin
                assert (instr_valid && instr_pc == held_pc && instr == held_instr
                        && instr_class == held_class && instr_fault == held_fault)
                else
                    stop_with_error($sformatf("mismatch at %0t ns: output at pc %h changed %s",
                                              $time, held_pc, "under back-pressure"));
            end
            // one cycle after a redirect the output register can only hold an old word.
            if (old_state == 2)
                old_state = instr_valid ? 1 : 0;
            if (instr_valid && instr_ready)
            begin
                if (old_state == 1)
                begin
                    pc_expect = old_pc;
                    old_state = 0;
                end
                else
                begin
                    pc_expect = exp_pc;
                    exp_pc    = exp_pc + 32'd4;
                end
                fault_expect = (pc_expect >= mem_limit);
                word_expect  = fault_expect ? 32'h0 : mem[pc_expect[9:2]];
                assert (instr_pc == pc_expect)
                else
                    stop_with_error($sformatf("mismatch at %0t ns: pc %h, expected %h",
                                              $time, instr_pc, pc_expect));
                assert (instr_fault == fault_expect)
                else
                    stop_with_error($sformatf("mismatch at %0t ns: fault %b at pc %h",
                                              $time, instr_fault, pc_expect));
                assert (fault_expect || instr == word_expect)
                else
                    stop_with_error($sformatf("mismatch at %0t ns: instr %h, expected %h",
                                              $time, instr, word_expect));
                assert (instr_class == classify_word(word_expect, fault_expect))
                else
                    stop_with_error($sformatf("mismatch at %0t ns: class %s for word %h",
                                              $time, instr_class.name(), word_expect));
                n_xfer++;
            end
            if (redirect_valid)
            begin
                if (old_state != 1)
                begin
                    old_pc    = exp_pc;
                    old_state = 2;
                end
                exp_pc = {redirect_pc[31:2], 2'b00};
            end
            stalled    = instr_valid && !instr_ready;
            held_pc    = instr_pc;
            held_instr = instr;
            held_class = instr_class;
            held_fault = instr_fault;

            instr_ready <= (lfsr_bits(2) != 0); // ready 3 cycles in 4.
            if (lfsr_bits(8) < 6)
            begin
                redirect_valid <= 1'b1;
                redirect_pc    <= pick_target();
            end
            else
                redirect_valid <= 1'b0;
        end

        // memory side, 0 to 3 wait states per read.
        if (psel && !penable)
        begin
            wait_left = int'(lfsr_bits(2));
            pready <= (wait_left == 0);
        end
        else if (psel && penable && !pready)
        begin
            wait_left = wait_left - 1;
            pready <= (wait_left == 0);
        end
        else
            pready <= 1'b0;
        prdata  <= mem[paddr[9:2]];
        pslverr <= (paddr >= mem_limit);
    end

    initial
    begin
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        wait (n_xfer == num_outputs);
        $display(">>> PASS");
        $finish;
    end

    initial
    begin
        #(num_outputs * cycles_per_output * clk_period);
        stop_with_error($sformatf("timeout at %0t ns: only %0d of %0d outputs transferred",
                                  $time, n_xfer, num_outputs));
    end
endmodule

// ==== testbench/fetch_props.sv ====
`include "fetch_settings.svh"

module fetch_props
(
    input logic                     clk,
    input logic                     reset,
    input logic                     psel,
    input logic                     penable,
    input logic                     pwrite,
    input logic [`FETCH_ADDR_W-1:0] paddr,
    input logic                     pready
);
    timeunit 1ns;
    timeprecision 1ps;

    // setup lasts exactly one cycle.
    setup_then_access: assert property (@(posedge clk) disable iff (reset)
        psel && !penable |=> psel && penable)
    else $error("APB setup phase not followed by an access phase");

    access_after_setup: assert property (@(posedge clk) disable iff (reset)
        $rose(penable) |-> $past(psel && !penable))
    else $error("penable rose without a setup cycle before it");

    hold_until_ready: assert property (@(posedge clk) disable iff (reset)
        psel && !(penable && pready) |=> psel && $stable(paddr))
    else $error("psel dropped or paddr moved before pready");

    read_only: assert property (@(posedge clk) disable iff (reset) !pwrite)
    else $error("pwrite driven high on the fetch port");
endmodule

bind apb_fetch_stage fetch_props i_props
(
    .clk(clk),
    .reset(reset),
    .psel(psel),
    .penable(penable),
    .pwrite(pwrite),
    .paddr(paddr),
    .pready(pready)
);

// ==== hw/fetch_top.sv ====
`include "fetch_settings.svh"

module fetch_top
    import fetch_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     redirect_valid,
    input  logic [`FETCH_ADDR_W-1:0] redirect_pc,
    output logic                     psel,
    output logic                     penable,
    output logic                     pwrite,
    output logic [`FETCH_ADDR_W-1:0] paddr,
    input  logic [31:0]              prdata,
    input  logic                     pready,
    input  logic                     pslverr,
    output logic                     instr_valid,
    input  logic                     instr_ready,
    output logic [`FETCH_ADDR_W-1:0] instr_pc,
    output logic [31:0]              instr,
    output opcode_class_e            instr_class,
    output logic                     instr_fault
);
    logic epoch; // current path tag from the pc stage.

    fetch_req_if req_if();
    fetch_rsp_if rsp_if();

    pc_stage i_pc_stage
    (
        .clk(clk),
        .reset(reset),
        .redirect_valid(redirect_valid),
        .redirect_pc(redirect_pc),
        .req(req_if.source),
        .epoch(epoch)
    );

    apb_fetch_stage i_apb_fetch_stage
    (
        .clk(clk),
        .reset(reset),
        .req(req_if.sink),
        .rsp(rsp_if.source),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr)
    );

    predecode_stage i_predecode_stage
    (
        .clk(clk),
        .reset(reset),
        .rsp(rsp_if.sink),
        .epoch(epoch),
        .instr_valid(instr_valid),
        .instr_ready(instr_ready),
        .instr_pc(instr_pc),
        .instr(instr),
        .instr_class(instr_class),
        .instr_fault(instr_fault)
    );
endmodule

// ==== hw/predecode_stage.sv ====
`include "fetch_settings.svh"

module predecode_stage
    import fetch_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    fetch_rsp_if.sink                rsp,
    input  logic                     epoch,
    output logic                     instr_valid,
    input  logic                     instr_ready,
    output logic [`FETCH_ADDR_W-1:0] instr_pc,
    output logic [31:0]              instr,
    output opcode_class_e            instr_class,
    output logic                     instr_fault
);
    logic          stale;
    logic          out_free;
    logic          take_live;
    opcode_class_e cls;

    assign stale     = (rsp.epoch != epoch); // fetched before the last redirect.
    assign out_free  = !instr_valid || instr_ready;
    assign rsp.ready = stale || out_free;     // stale words are always swallowed.
    assign take_live = rsp.valid && !stale && out_free;

    always_comb
    begin
        if (rsp.fault || rsp.instr[1:0] != 2'b11)
            cls = cls_illegal;
        else
        begin
            case (rsp.instr[6:2])
                5'b01100, 5'b00100: cls = cls_alu;
                5'b00000:           cls = cls_load;
                5'b01000:           cls = cls_store;
                5'b11000:           cls = cls_branch;
                5'b11011, 5'b11001: cls = cls_jump;
                5'b01101, 5'b00101: cls = cls_upper;
                5'b11100:           cls = cls_system;
                default:            cls = cls_illegal;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            instr_valid <= 1'b0;
        else if (take_live)
            instr_valid <= 1'b1;
        else if (instr_ready)
            instr_valid <= 1'b0;
    end

    // data holds while decode stalls.
    always_ff @(posedge clk)
    begin
        if (take_live)
        begin
            instr_pc    <= rsp.pc;
            instr       <= rsp.instr;
            instr_class <= cls;
            instr_fault <= rsp.fault;
        end
    end
endmodule

// ==== hw/apb_fetch_stage.sv ====
`include "fetch_settings.svh"

module apb_fetch_stage
    import fetch_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    fetch_req_if.sink                req,
    fetch_rsp_if.source              rsp,
    output logic                     psel,
    output logic                     penable,
    output logic                     pwrite,
    output logic [`FETCH_ADDR_W-1:0] paddr,
    input  logic [31:0]              prdata,
    input  logic                     pready,
    input  logic                     pslverr
);
    apb_state_e state;

    logic [`FETCH_ADDR_W-1:0] paddr_q;
    logic                     epoch_q;
    logic                     killed; // a redirect came after this read was issued.
    logic                     rsp_valid_q;
    logic [`FETCH_ADDR_W-1:0] rsp_pc_q;
    logic                     rsp_epoch_q;
    logic [31:0]              rsp_instr_q;
    logic                     rsp_fault_q;

    // one read at a time, and only with room to park its result.
    assign req.ready = (state == st_idle) && !rsp_valid_q;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state       <= st_idle;
            rsp_valid_q <= 1'b0;
            killed      <= 1'b0;
        end
        else
        begin
            if (rsp.valid && rsp.ready)
                rsp_valid_q <= 1'b0;
            // watch the epoch until predecode has taken the word.
            if ((state != st_idle || rsp_valid_q) && req.epoch != epoch_q)
                killed <= 1'b1;
            case (state)
                st_idle:
                begin
                    if (req.valid && req.ready)
                    begin
                        state  <= st_setup;
                        killed <= 1'b0;
                    end
                end
                st_setup:
                    state <= st_access;
                st_access:
                begin
                    if (pready)
                    begin
                        state       <= st_idle;
                        rsp_valid_q <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == st_idle && req.valid && req.ready)
        begin
            paddr_q <= req.pc;
            epoch_q <= req.epoch;
        end
        if (state == st_access && pready)
        begin
            rsp_instr_q <= prdata;
            rsp_fault_q <= pslverr;
            rsp_pc_q    <= paddr_q;
            rsp_epoch_q <= epoch_q;
        end
    end

    assign psel    = (state != st_idle);
    assign penable = (state == st_access);
    assign pwrite  = 1'b0; // read-only port.
    assign paddr   = paddr_q;

    assign rsp.valid = rsp_valid_q;
    assign rsp.pc    = rsp_pc_q;
    // two redirects can bring the 1-bit epoch back to its old value,
    // so a killed word always shows the opposite of the current epoch.
    assign rsp.epoch = (killed || req.epoch != rsp_epoch_q) ? ~req.epoch : rsp_epoch_q;
    assign rsp.instr = rsp_instr_q;
    assign rsp.fault = rsp_fault_q;
endmodule

// ==== hw/pc_stage.sv ====
`include "fetch_settings.svh"

module pc_stage
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     redirect_valid,
    input  logic [`FETCH_ADDR_W-1:0] redirect_pc,
    fetch_req_if.source              req,
    output logic                     epoch
);
    logic [`FETCH_ADDR_W-1:0] pc;
    logic [`FETCH_ADDR_W-3:0] pc_word_next;

    // word address only, low two bits stay zero.
    pc_incrementer
    #(
        .width(`FETCH_ADDR_W - 2)
    )
    i_inc
    (
        .value(pc[`FETCH_ADDR_W-1:2]),
        .result(pc_word_next)
    );

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc    <= `FETCH_RESET_PC;
            epoch <= 1'b0;
        end
        else if (redirect_valid)
        begin
            // redirect wins over a transfer in the same cycle.
            pc    <= {redirect_pc[`FETCH_ADDR_W-1:2], 2'b00};
            epoch <= ~epoch;
        end
        else if (req.valid && req.ready)
        begin
            pc <= {pc_word_next, 2'b00};
        end
    end

    assign req.valid = 1'b1; // always a next address to offer.
    assign req.pc    = pc;
    assign req.epoch = epoch;
endmodule

// ==== hw/pc_incrementer.sv ====
`include "fetch_settings.svh"

module pc_incrementer
#(
    parameter int width = 30
)
(
    input  logic [width-1:0] value,
    output logic [width-1:0] result
);
    localparam int blk_w = `FETCH_BLOCK_W;
    localparam int n_blk = width / blk_w;
    localparam int low_w = n_blk * blk_w;

    logic [n_blk:0] carry;

    assign carry[0] = 1'b1; // the +1 enters at block 0.

    // each block precomputes its sum; the carry only selects.
    for (genvar i = 0; i < n_blk; i++)
    begin : g_blk
        logic [blk_w-1:0] seg;
        logic [blk_w-1:0] seg_inc;
        logic             seg_full;

        assign seg      = value[i*blk_w +: blk_w];
        assign seg_inc  = seg + blk_w'(1);
        assign seg_full = &seg;

        assign result[i*blk_w +: blk_w] = carry[i] ? seg_inc : seg;
        assign carry[i+1]               = carry[i] & seg_full;
    end

    // narrow top bits left over when width is not a multiple of the block.
    if (low_w < width)
    begin : g_rem
        localparam int rem_w = width - low_w;

        assign result[width-1:low_w] = value[width-1:low_w] + rem_w'(carry[n_blk]);
    end
endmodule

// ==== hw/fetch_ifs.sv ====
`include "fetch_settings.svh"

// pc stage to fetch stage: one fetch address per transfer.
interface fetch_req_if;
    logic                     valid;
    logic                     ready;
    logic [`FETCH_ADDR_W-1:0] pc;
    logic                     epoch;

    modport source
    (
        output valid, pc, epoch,
        input  ready
    );

    modport sink
    (
        input  valid, pc, epoch,
        output ready
    );
endinterface

// fetch stage to predecode: the fetched word and where it came from.
interface fetch_rsp_if;
    logic                     valid;
    logic                     ready;
    logic [`FETCH_ADDR_W-1:0] pc;
    logic                     epoch;
    logic [31:0]              instr;
    logic                     fault;

    modport source
    (
        output valid, pc, epoch, instr, fault,
        input  ready
    );

    modport sink
    (
        input  valid, pc, epoch, instr, fault,
        output ready
    );
endinterface

// ==== hw/fetch_pkg.sv ====
package fetch_pkg;

    // coarse opcode class handed to decode.
    typedef enum logic [2:0]
    {
        cls_alu     = 3'd0, // OP and OP-IMM.
        cls_load    = 3'd1,
        cls_store   = 3'd2,
        cls_branch  = 3'd3,
        cls_jump    = 3'd4, // JAL and JALR.
        cls_upper   = 3'd5, // LUI and AUIPC.
        cls_system  = 3'd6,
        cls_illegal = 3'd7  // anything else, or a faulted word.
    } opcode_class_e;

    // APB requester phases.
    typedef enum logic [1:0]
    {
        st_idle   = 2'd0,
        st_setup  = 2'd1,
        st_access = 2'd2
    } apb_state_e;

endpackage

// ==== hw/fetch_settings.svh ====
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// first fetch address after reset.
`define FETCH_RESET_PC 32'h0000_0000

// byte address width of the fetch path.
`define FETCH_ADDR_W 32

// block width of the carry-select incrementer.
`define FETCH_BLOCK_W 4

`endif
